// ==== logic/conv_pool_cfg.svh ====
`ifndef CONV_POOL_CFG_SVH
`define CONV_POOL_CFG_SVH

// image geometry in bytes, width is a whole number of bus words
`define IMG_W        12
`define IMG_H        10

`define ROW_WORDS    (`IMG_W / 4)               // bus words per image row
`define POOL_W       ((`IMG_W - 2) / 2)         // pooled results per row
`define POOL_H       ((`IMG_H - 2) / 2)         // pooled rows

// byte addresses on the bus
`define WEIGHT_BASE  32'h4001_0000              // three kernel words
`define IMAGE_BASE   32'h4000_0000              // image row 0, rows are contiguous
`define RESULT_BASE  32'h4002_0000              // packed pooled results

`define CONV_SHIFT   7                          // scaling of a positive sum

`endif

// ==== logic/conv_pool_pkg.sv ====
`include "conv_pool_cfg.svh"

package conv_pool_pkg;

    typedef logic signed [7:0] pixel_t;
    typedef logic signed [7:0] weight_t;
    typedef weight_t [8:0] kernel_t;            // row-major, weight 0 in the low byte
    typedef logic [31:0] word_t;
    typedef pixel_t [3:0][3:0] patch_t;         // [row][col] around one pooling cell
    typedef pixel_t [3:0][`IMG_W-1:0] rows_t;   // [buffer row][byte]

    typedef enum logic [1:0] {
        trans_idle   = 2'b00,
        trans_nonseq = 2'b10
    } trans_e;

    typedef struct packed {
        word_t  haddr;
        trans_e htrans;
        logic   hwrite;
        word_t  hwdata;
    } bus_req_t;

    typedef enum logic [3:0] {
        st_idle, st_w_req, st_w_settle, st_w_wait,
        st_r_req, st_r_settle, st_r_wait, st_compute,
        st_wr_req, st_wr_settle, st_wr_wait, st_shift,
        st_done
    } ctrl_state_e;

    typedef enum logic [2:0] {
        step_none, step_weight, step_row, step_compute,
        step_result, step_clear
    } step_e;

endpackage

// ==== logic/scan_counter.sv ====
`timescale 1ns/1ps
`include "conv_pool_cfg.svh"

module scan_counter import conv_pool_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  step_e      step,
    output word_t      rd_addr,
    output word_t      wr_addr,
    output logic       weights_done,
    output logic       fetch_done,
    output logic       row_group_done,
    output logic       all_done,
    output logic       word_full,
    output logic [1:0] buf_row,
    output logic [2:0] buf_word,
    output logic [2:0] pool_col,
    output logic [1:0] lane
);

    logic       weight_phase;  // buf_word counts kernel words while set
    logic [2:0] pool_row;
    logic [7:0] out_cnt;       // result words already written
    word_t      img_row;

    always_ff @(posedge clk) begin
        if (!reset || step == step_clear) begin
            weight_phase <= 1'b1;
            buf_word     <= '0;
            buf_row      <= '0;
            pool_col     <= '0;
            pool_row     <= '0;
            lane         <= '0;
            out_cnt      <= '0;
        end else begin
            case (step)
                step_weight: begin
                    if (buf_word == 3'd2) begin
                        buf_word     <= '0;
                        weight_phase <= 1'b0;
                    end else begin
                        buf_word <= buf_word + 3'd1;
                    end
                end
                step_row: begin
                    if (buf_word == 3'(`ROW_WORDS - 1)) begin
                        buf_word <= '0;
                        // later fetches refill only rows 2 and 3
                        buf_row  <= (buf_row == 2'd3) ? 2'd2 : buf_row + 2'd1;
                    end else begin
                        buf_word <= buf_word + 3'd1;
                    end
                end
                step_compute: begin
                    lane <= lane + 2'd1;  // wraps, packing runs across pooled rows
                    if (row_group_done) begin
                        pool_col <= '0;
                        pool_row <= pool_row + 3'd1;
                    end else begin
                        pool_col <= pool_col + 3'd1;
                    end
                end
                step_result: out_cnt <= out_cnt + 8'd1;
                default: ;
            endcase
        end
    end

    // pooled row p covers image rows 2p to 2p+3
    assign img_row = word_t'(buf_row) + (word_t'(pool_row) << 1);

    assign rd_addr = weight_phase ? `WEIGHT_BASE + (word_t'(buf_word) << 2)
                                  : `IMAGE_BASE + img_row * `IMG_W + (word_t'(buf_word) << 2);
    assign wr_addr = `RESULT_BASE + (word_t'(out_cnt) << 2);

    // each flag says the word or cell now in progress is the last of its group
    assign weights_done   = weight_phase && (buf_word == 3'd2);
    assign fetch_done     = (buf_row == 2'd3) && (buf_word == 3'(`ROW_WORDS - 1));
    assign row_group_done = (pool_col == 3'(`POOL_W - 1));
    assign all_done       = row_group_done && (pool_row == 3'(`POOL_H - 1));
    assign word_full      = (lane == 2'd3) || all_done;  // last word may be partial

    assert property (@(posedge clk) disable iff (!reset) pool_col < 3'(`POOL_W));

endmodule

// ==== logic/row_buffer.sv ====
`timescale 1ns/1ps

module row_buffer import conv_pool_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_row,
    input  logic       shift_rows,
    input  logic [1:0] buf_row,
    input  logic [2:0] buf_word,
    input  word_t      hrdata,
    output rows_t      rows
);

    logic [4:0] byte_base;  // first byte of the addressed word

    assign byte_base = {buf_word, 2'b00};

    // rows 0 and 1 are the upper half of the window, rows 2 and 3 the lower half
    always_ff @(posedge clk) begin
        if (!reset) begin
            rows <= '0;
        end else if (shift_rows) begin
            // lower half becomes the upper half of the next pooled row
            rows[0] <= rows[2];
            rows[1] <= rows[3];
        end else if (load_row) begin
            rows[buf_row][byte_base +: 4] <= hrdata;  // lowest byte at lowest column
        end
    end

endmodule

// ==== logic/conv_pool_unit.sv ====
`timescale 1ns/1ps
`include "conv_pool_cfg.svh"

module conv_pool_unit import conv_pool_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_weight,
    input  logic [1:0] weight_index,
    input  logic       compute,
    input  word_t      hrdata,
    input  rows_t      rows,
    input  logic [2:0] pool_col,
    input  logic [1:0] lane,
    output word_t      result_word
);

    kernel_t    kernel;
    patch_t     patch;
    logic [3:0] col_base;
    logic [7:0] c00;
    logic [7:0] c01;
    logic [7:0] c10;
    logic [7:0] c11;
    logic [7:0] top_max;
    logic [7:0] bot_max;
    logic [7:0] cell_max;

    // one 3x3 output at offset (dy, dx) inside the patch, ReLU then scale
    function automatic logic [7:0] conv_at(input patch_t p, input kernel_t k,
                                           input int dy, input int dx);
        logic signed [15:0] prod;
        logic signed [19:0] acc;  // nine full-range products fit in 19 bits
        acc = '0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                prod = $signed(p[dy + i][dx + j]) * $signed(k[3 * i + j]);
                acc  = acc + prod;
            end
        end
        if (acc > 0) begin
            return 8'(acc >>> `CONV_SHIFT);
        end
        return 8'd0;
    endfunction

    always_ff @(posedge clk) begin
        if (load_weight) begin
            case (weight_index)
                2'd0:    kernel[3:0] <= hrdata;
                2'd1:    kernel[7:4] <= hrdata;
                default: kernel[8]   <= hrdata[7:0];  // upper bytes of word 2 unused
            endcase
        end
    end

    assign col_base = {pool_col, 1'b0};

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                patch[r][c] = rows[r][col_base + c];
            end
        end
    end

    assign c00 = conv_at(patch, kernel, 0, 0);
    assign c01 = conv_at(patch, kernel, 0, 1);
    assign c10 = conv_at(patch, kernel, 1, 0);
    assign c11 = conv_at(patch, kernel, 1, 1);

    assign top_max  = (c00 > c01) ? c00 : c01;  // unsigned byte compare
    assign bot_max  = (c10 > c11) ? c10 : c11;
    assign cell_max = (top_max > bot_max) ? top_max : bot_max;

    always_ff @(posedge clk) begin
        if (!reset) begin
            result_word <= '0;
        end else if (compute) begin
            if (lane == 2'd0) begin
                // a full word has gone out by now, so start clean
                result_word <= {24'd0, cell_max};
            end else begin
                result_word[{lane, 3'b000} +: 8] <= cell_max;
            end
        end
    end

endmodule

// ==== logic/conv_pool_ctrl.sv ====
`timescale 1ns/1ps

module conv_pool_ctrl import conv_pool_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  logic     hready,
    output logic     finish,
    output bus_req_t bus_req,
    output step_e    step,
    output logic     load_weight,
    output logic     load_row,
    output logic     shift_rows,
    input  word_t    rd_addr,
    input  word_t    wr_addr,
    input  word_t    result_word,
    input  logic     weights_done,
    input  logic     fetch_done,
    input  logic     row_group_done,
    input  logic     all_done,
    input  logic     word_full
);

    ctrl_state_e state;
    logic        row_end;    // cell before the write closed a pooled row
    logic        last_cell;  // cell before the write was the final one

    // strobes fire in the completing cycle, so counters and buffers see old indices
    always_comb begin
        step        = step_none;
        load_weight = 1'b0;
        load_row    = 1'b0;
        shift_rows  = 1'b0;
        case (state)
            st_idle: begin
                if (start) begin
                    step = step_clear;
                end
            end
            st_w_wait: begin
                if (hready) begin
                    step        = step_weight;
                    load_weight = 1'b1;
                end
            end
            st_r_wait: begin
                if (hready) begin
                    step     = step_row;
                    load_row = 1'b1;
                end
            end
            st_compute: step = step_compute;
            st_wr_wait: begin
                if (hready) begin
                    step = step_result;
                end
            end
            st_shift: shift_rows = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= st_idle;
            bus_req   <= '0;
            finish    <= 1'b0;
            row_end   <= 1'b0;
            last_cell <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_w_req;
                    end
                end
                st_w_req: begin
                    if (hready) begin
                        bus_req.haddr  <= rd_addr;
                        bus_req.htrans <= trans_nonseq;
                        bus_req.hwrite <= 1'b0;
                        state          <= st_w_settle;
                    end
                end
                st_w_settle: begin
                    bus_req.htrans <= trans_idle;
                    state          <= st_w_wait;
                end
                st_w_wait: begin
                    if (hready) begin
                        state <= weights_done ? st_r_req : st_w_req;
                    end
                end
                st_r_req: begin
                    if (hready) begin
                        bus_req.haddr  <= rd_addr;
                        bus_req.htrans <= trans_nonseq;
                        bus_req.hwrite <= 1'b0;
                        state          <= st_r_settle;
                    end
                end
                st_r_settle: begin
                    bus_req.htrans <= trans_idle;
                    state          <= st_r_wait;
                end
                st_r_wait: begin
                    if (hready) begin
                        state <= fetch_done ? st_compute : st_r_req;
                    end
                end
                st_compute: begin
                    if (word_full) begin
                        row_end   <= row_group_done;
                        last_cell <= all_done;
                        state     <= st_wr_req;
                    end else if (row_group_done) begin
                        state <= st_shift;
                    end
                end
                st_wr_req: begin
                    if (hready) begin
                        bus_req.haddr  <= wr_addr;
                        bus_req.htrans <= trans_nonseq;
                        bus_req.hwrite <= 1'b1;
                        bus_req.hwdata <= result_word;
                        state          <= st_wr_settle;
                    end
                end
                st_wr_settle: begin
                    bus_req.htrans <= trans_idle;
                    state          <= st_wr_wait;
                end
                st_wr_wait: begin
                    if (hready) begin
                        bus_req.hwrite <= 1'b0;
                        if (last_cell) begin
                            state <= st_done;
                        end else if (row_end) begin
                            state <= st_shift;
                        end else begin
                            state <= st_compute;
                        end
                    end
                end
                st_shift: state <= st_r_req;
                st_done:  finish <= 1'b1;  // held until reset
                default:  state <= st_idle;
            endcase
        end
    end

    // a transfer only opens right after a request state that saw hready high
    assert property (@(posedge clk) disable iff (!reset)
        bus_req.htrans == trans_nonseq |->
            $past(hready) && ($past(state) inside {st_w_req, st_r_req, st_wr_req}));

    assert property (@(posedge clk) disable iff (!reset) finish |=> finish);

endmodule

// ==== logic/conv_pool_top.sv ====
`timescale 1ns/1ps

module conv_pool_top import conv_pool_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    output logic     finish,
    output bus_req_t bus_req,
    input  word_t    hrdata,
    input  logic     hready
);

    step_e      step;
    logic       load_weight;
    logic       load_row;
    logic       shift_rows;
    word_t      rd_addr;
    word_t      wr_addr;
    word_t      result_word;
    logic       weights_done;
    logic       fetch_done;
    logic       row_group_done;
    logic       all_done;
    logic       word_full;
    logic [1:0] buf_row;
    logic [2:0] buf_word;
    logic [2:0] pool_col;
    logic [1:0] lane;
    rows_t      rows;

    conv_pool_ctrl u_ctrl (
        .clk(clk), .reset(reset), .start(start), .hready(hready),
        .finish(finish), .bus_req(bus_req), .step(step),
        .load_weight(load_weight), .load_row(load_row), .shift_rows(shift_rows),
        .rd_addr(rd_addr), .wr_addr(wr_addr), .result_word(result_word),
        .weights_done(weights_done), .fetch_done(fetch_done),
        .row_group_done(row_group_done), .all_done(all_done), .word_full(word_full)
    );

    scan_counter u_counter (
        .clk(clk), .reset(reset), .step(step),
        .rd_addr(rd_addr), .wr_addr(wr_addr),
        .weights_done(weights_done), .fetch_done(fetch_done),
        .row_group_done(row_group_done), .all_done(all_done), .word_full(word_full),
        .buf_row(buf_row), .buf_word(buf_word), .pool_col(pool_col), .lane(lane)
    );

    row_buffer u_rows (
        .clk(clk), .reset(reset), .load_row(load_row), .shift_rows(shift_rows),
        .buf_row(buf_row), .buf_word(buf_word), .hrdata(hrdata), .rows(rows)
    );

    // weight words are counted on the same word counter as row words
    conv_pool_unit u_unit (
        .clk(clk), .reset(reset), .load_weight(load_weight),
        .weight_index(buf_word[1:0]), .compute(step == step_compute),
        .hrdata(hrdata), .rows(rows), .pool_col(pool_col), .lane(lane),
        .result_word(result_word)
    );

endmodule

// ==== dv/tb_conv_pool.sv ====
`timescale 1ns/1ps
`include "conv_pool_cfg.svh"

module tb_conv_pool import conv_pool_pkg::*; ();

    localparam int NUM_WEIGHT = 3;
    localparam int NUM_IMAGE  = `IMG_W * `IMG_H / 4;
    localparam int NUM_RESULT = (`POOL_W * `POOL_H + 3) / 4;
    localparam int VEC_WORDS  = NUM_WEIGHT + NUM_IMAGE + NUM_RESULT;
    localparam int RUN_LIMIT  = 50 * VEC_WORDS + 200;   // cycles allowed for one run
    localparam int WATCHDOG   = 2 * (RUN_LIMIT + 60);   // both runs, resets and tails

    logic     clk = 1'b0;
    logic     reset;
    logic     start;
    logic     finish;
    logic     hready;
    word_t    hrdata;
    bus_req_t bus_req;

    word_t       vec [0:VEC_WORDS-1];  // weights, image, expected results
    logic [31:0] lfsr = 32'hf6f2;
    int          errors;
    int          checks;

    // bus model state of the current run
    logic  pending;
    logic  pend_write;
    word_t pend_data;
    int    pend_age;
    int    reads_issued;
    int    writes_issued;
    int    writes_done;
    logic  finish_seen;

    conv_pool_top dut0 (
        .clk(clk), .reset(reset), .start(start), .finish(finish),
        .bus_req(bus_req), .hrdata(hrdata), .hready(hready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = galois_step(lfsr);
        b    = lfsr[0];
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic note_failure(input string name, input string what);
        errors++;
        $display("%s: %s at %0t ns", name, what, $time);
    endtask

    // one step of the bus model, 1 ns after a rising edge
    task automatic bus_step(input string name, input logic backpressure);
        word_t addr;
        logic  b0;
        logic  b1;
        if (pending) begin
            pend_age++;
            if (pend_age >= 2 && hready) begin  // first ready edge after the settle cycle
                pending = 1'b0;
                if (pend_write) begin
                    writes_done++;
                end
            end
        end
        if (bus_req.htrans == trans_nonseq) begin
            addr = bus_req.haddr;
            if (!hready) begin
                note_failure(name, "request registered while hready was low");
            end
            if (pending) begin
                note_failure(name, "request overlaps an unfinished transfer");
            end
            if (finish_seen) begin
                note_failure(name, "request issued after finish");
            end
            pending    = 1'b1;
            pend_age   = 0;
            pend_write = bus_req.hwrite;
            if (bus_req.hwrite) begin
                check_value($sformatf("%s write address %0d", name, writes_issued),
                            `RESULT_BASE + 4 * writes_issued, addr);
                if (writes_issued < NUM_RESULT) begin
                    check_value($sformatf("%s result word %0d", name, writes_issued),
                                vec[NUM_WEIGHT + NUM_IMAGE + writes_issued], bus_req.hwdata);
                end
                writes_issued++;
            end else begin
                reads_issued++;
                pend_data = addr ^ 32'h5a5a_a5a5;  // unmapped space
                if (addr[1:0] != 2'b00) begin
                    note_failure(name, "read address is not word aligned");
                end else if (addr >= `WEIGHT_BASE && addr < `WEIGHT_BASE + 4 * NUM_WEIGHT) begin
                    pend_data = vec[(addr - `WEIGHT_BASE) >> 2];
                end else if (addr >= `IMAGE_BASE && addr < `IMAGE_BASE + 4 * NUM_IMAGE) begin
                    pend_data = vec[NUM_WEIGHT + ((addr - `IMAGE_BASE) >> 2)];
                end else begin
                    note_failure(name, "read address outside the weight and image regions");
                end
            end
        end
        if (finish && !finish_seen) begin
            finish_seen = 1'b1;
            check_value({name, " writes done at finish"}, NUM_RESULT, writes_done);
        end else if (!finish && finish_seen) begin
            note_failure(name, "finish fell without reset");
        end
        if (backpressure) begin
            draw_bit(b0);
            draw_bit(b1);
            hready = !(b0 && b1);  // low about one cycle in four
        end else begin
            hready = 1'b1;
        end
        // read data is valid only for the edge that completes the transfer
        if (pending && !pend_write && pend_age >= 1 && hready) begin
            hrdata = pend_data;
        end else begin
            hrdata = ~pend_data;
        end
    endtask

    task automatic run_test(input string name, input logic backpressure);
        reset         = 1'b0;
        start         = 1'b0;
        hready        = 1'b1;
        hrdata        = '0;
        pending       = 1'b0;
        pend_write    = 1'b0;
        pend_data     = '0;
        pend_age      = 0;
        reads_issued  = 0;
        writes_issued = 0;
        writes_done   = 0;
        finish_seen   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        check_value({name, " reset finish"}, 32'd0, word_t'(finish));
        check_value({name, " reset htrans"}, word_t'(trans_idle), word_t'(bus_req.htrans));
        check_value({name, " reset hwrite"}, 32'd0, word_t'(bus_req.hwrite));
        check_value({name, " reset haddr"}, 32'd0, bus_req.haddr);
        reset = 1'b1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        bus_step(name, backpressure);
        while (!finish_seen) begin
            @(posedge clk);
            #1;
            bus_step(name, backpressure);
        end
        check_value({name, " read transfers"}, NUM_WEIGHT + NUM_IMAGE, reads_issued);
        check_value({name, " write transfers"}, NUM_RESULT, writes_issued);
        repeat (50) begin  // bus must stay quiet once finished
            @(posedge clk);
            #1;
            bus_step(name, backpressure);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        $readmemh("dv/conv_pool_vectors.hex", vec);
        run_test("hready high", 1'b0);
        run_test("hready lfsr", 1'b1);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles without the runs completing", WATCHDOG);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== dv/conv_pool_vectors.hex ====
// one 32-bit word per line, lowest byte at the lowest address
// 3 kernel words, 30 image words (12x10 bytes, row-major), 5 expected result words
// kernel rows: 100 120 127 / 3 -7 5 / -50 -60 -40, ninth weight in the low byte of word 2
037F7864
C4CE05F9
A5A5A5D8
// image, each pixel holds its own byte offset
03020100
07060504
0B0A0908
0F0E0D0C
13121110
17161514
1B1A1918
1F1E1D1C
23222120
27262524
2B2A2928
2F2E2D2C
33323130
37363534
3B3A3938
3F3E3D3C
43424140
47464544
4B4A4948
4F4E4D4C
53525150
57565554
5B5A5958
5F5E5D5C
63626160
67666564
6B6A6968
6F6E6D6C
73727170
77767574
// pooled results, four per word, lane 0 in the low byte
03000000
25221F06
47442B28
69504D4A
75726F6C

// ==== all.f ====
+incdir+logic
logic/conv_pool_pkg.sv
logic/scan_counter.sv
logic/row_buffer.sv
logic/conv_pool_unit.sv
logic/conv_pool_ctrl.sv
logic/conv_pool_top.sv
dv/tb_conv_pool.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv_pool
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh dv/*.sv dv/*.hex)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
